//--- rtl/icache_pkg.sv
package icache_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Cache geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int XLEN       = 32;                  // Address and data width
  localparam int WAYS       = 2;                   // Two ways, one LRU bit per set
  localparam int SETS       = 4;
  localparam int LINE_WORDS = 4;                   // 16-byte line

  localparam int BYTE_BITS  = $clog2(XLEN/8);      // Byte within a word
  localparam int IDX_BITS   = $clog2(SETS);
  localparam int OFFS_BITS  = $clog2(LINE_WORDS);  // Word within a line
  localparam int TAG_BITS   = XLEN - IDX_BITS - OFFS_BITS - BYTE_BITS;

  localparam int NC_BIT     = 31;                  // Set means uncached region

  // AXI read response code
  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  ////////////////////////////////////////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [XLEN-1:0]            addr_t;      // Byte address
  typedef logic [XLEN-1:0]            word_t;      // Instruction word
  typedef logic [IDX_BITS-1:0]        idx_t;
  typedef logic [TAG_BITS-1:0]        tag_t;
  typedef logic [OFFS_BITS-1:0]       offs_t;
  typedef logic [LINE_WORDS*XLEN-1:0] line_t;      // Word 0 in the low bits
  typedef logic [WAYS-1:0]            way_oh_t;    // One-hot way select

  // Memory FSM of the hit stage
  typedef enum logic [2:0] {
    ARMED,
    FLUSH,
    NONCACHEABLE,
    FILL,
    RECOVER
  } hit_state_e;

  // Commands to the bus unit
  typedef enum logic [1:0] {
    NOP,
    READ_LINE,
    READ_WORD
  } biu_cmd_e;

  ////////////////////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic  valid;
    addr_t adr;
    idx_t  idx;
    tag_t  tag;
    offs_t offs;
    logic  cacheable;
  } req_s;

  typedef struct packed {
    logic  hit;
    line_t line;
  } way_rsp_s;

  typedef struct packed {
    way_oh_t we;       // Line write, one bit per way
    idx_t    idx;
    tag_t    tag;
    line_t   line;
    logic    inval;    // Drop every valid bit in every way
  } way_wr_s;

  typedef struct packed {
    logic  ack;        // Single cycle, command done
    logic  err;
    line_t line;
    word_t word;
  } biu_rsp_s;

endpackage

//--- rtl/icache_setup.sv
module icache_setup (
  input  logic              clk_i,
  input  logic              rst_ni,

  input  logic              req_i,      // Fetch request from core
  input  icache_pkg::addr_t adr_i,
  input  logic              stall_i,    // Hit stage busy

  output icache_pkg::req_s  req_o       // Registered request
);

  logic              valid_q;
  icache_pkg::addr_t adr_q;

  ////////////////////////////////////////////////////////////////////////////
  // Request register
  ////////////////////////////////////////////////////////////////////////////

  // Valid flag, frozen while the hit stage stalls
  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      valid_q <= 1'b0;
    end
    else if (!stall_i)
    begin
      valid_q <= req_i;
    end
  end

  // Address only loads on an accepted request
  always_ff @(posedge clk_i)
  begin
    if (!stall_i && req_i)
    begin
      adr_q <= adr_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Address split
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    req_o.valid     = valid_q;
    req_o.adr       = adr_q;
    // Index sits right above the word offset
    req_o.idx       = adr_q[icache_pkg::OFFS_BITS + icache_pkg::BYTE_BITS +: icache_pkg::IDX_BITS];
    req_o.tag       = adr_q[icache_pkg::XLEN-1 -: icache_pkg::TAG_BITS];   // Upper bits
    req_o.offs      = adr_q[icache_pkg::BYTE_BITS +: icache_pkg::OFFS_BITS];
    // Single cacheability decode for the whole cache
    req_o.cacheable = ~adr_q[icache_pkg::NC_BIT];
  end

endmodule

//--- rtl/icache_way.sv
module icache_way #(
  parameter int WAY_ID = 0              // Slot in the way loop
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  input  icache_pkg::req_s     req_i,   // Lookup request
  input  icache_pkg::way_wr_s  wr_i,    // Fill or invalidate
  output icache_pkg::way_rsp_s rsp_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  icache_pkg::tag_t          tag_q  [icache_pkg::SETS];
  icache_pkg::line_t         line_q [icache_pkg::SETS];
  logic [icache_pkg::SETS-1:0] valid_q;   // One bit per set

  logic wr_en;                            // This way picked as victim
  logic tag_eq;

  assign wr_en = wr_i.we[WAY_ID];

  // Valid bits
  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      valid_q <= '0;
    end
    else if (wr_i.inval)
    begin
      valid_q <= '0;                      // Cache flush
    end
    else if (wr_en)
    begin
      valid_q[wr_i.idx] <= 1'b1;          // Line now filled
    end
  end

  // Tag and data arrays
  always_ff @(posedge clk_i)
  begin
    if (wr_en)
    begin
      tag_q[wr_i.idx]  <= wr_i.tag;
      line_q[wr_i.idx] <= wr_i.line;      // Whole line in one go
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////////////////////////////////////////

  // Flop read, answer in the same cycle
  assign tag_eq = (tag_q[req_i.idx] == req_i.tag);

  always_comb
  begin
    rsp_o.hit  = valid_q[req_i.idx] & tag_eq & req_i.cacheable;
    rsp_o.line = line_q[req_i.idx];       // Muxed later by the hit stage
  end

endmodule

//--- rtl/icache_hit.sv
module icache_hit (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  input  icache_pkg::req_s     req_i,                          // From setup stage
  input  icache_pkg::way_rsp_s way_rsp_i [icache_pkg::WAYS],   // From the ways
  input  logic                 flush_req_i,                    // Invalidate whole cache

  output icache_pkg::way_wr_s  wr_o,

  output icache_pkg::biu_cmd_e biu_cmd_o,
  output icache_pkg::addr_t    biu_adr_o,
  input  icache_pkg::biu_rsp_s biu_rsp_i,

  output logic                 stall_o,
  output icache_pkg::word_t    parcel_o,
  output logic                 parcel_valid_o,
  output logic                 parcel_error_o,
  output logic                 parcel_misaligned_o
);

  icache_pkg::hit_state_e      state_q, state_d;

  icache_pkg::way_oh_t         hits;
  icache_pkg::way_oh_t         victim_oh;
  icache_pkg::line_t           hit_line;
  logic                        hit_way;          // Index of the hitting way
  logic                        any_hit;
  logic                        cache_ack;        // Hit served this cycle
  logic                        fill_ok;          // Clean line back from the bus

  logic [icache_pkg::SETS-1:0] lru_q;            // Points at the victim way
  icache_pkg::line_t           fill_line_q;
  logic                        fill_err_q;
  logic                        pend_q;           // Fill parcel waits in RECOVER

  ////////////////////////////////////////////////////////////////////////////
  // Way select
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    hits     = '0;
    hit_line = '0;
    hit_way  = 1'b0;
    for (int w = 0; w < icache_pkg::WAYS; w++)
    begin
      hits[w] = way_rsp_i[w].hit;
      if (way_rsp_i[w].hit)
      begin
        hit_line = way_rsp_i[w].line;
        hit_way  = 1'(w);
      end
    end
  end

  assign any_hit   = |hits;
  assign cache_ack = (state_q == icache_pkg::ARMED) & req_i.valid & req_i.cacheable
                   & any_hit & ~flush_req_i;
  assign fill_ok   = (state_q == icache_pkg::FILL) & biu_rsp_i.ack & ~biu_rsp_i.err;
  assign victim_oh = icache_pkg::way_oh_t'(1) << lru_q[req_i.idx];

  ////////////////////////////////////////////////////////////////////////////
  // Memory FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      icache_pkg::ARMED:
        if (flush_req_i)                                  state_d = icache_pkg::FLUSH;
        else if (req_i.valid && !req_i.cacheable)         state_d = icache_pkg::NONCACHEABLE;
        else if (req_i.valid && !any_hit)                 state_d = icache_pkg::FILL;
      icache_pkg::FLUSH:        state_d = icache_pkg::RECOVER;  // Valid bits cleared here
      icache_pkg::NONCACHEABLE: if (biu_rsp_i.ack) state_d = icache_pkg::ARMED;
      icache_pkg::FILL:         if (biu_rsp_i.ack) state_d = icache_pkg::RECOVER;
      icache_pkg::RECOVER:      state_d = icache_pkg::ARMED;
      default:                  state_d = icache_pkg::ARMED;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= icache_pkg::ARMED;
      pend_q  <= 1'b0;
      lru_q   <= '0;
    end
    else
    begin
      state_q <= state_d;
      pend_q  <= (state_q == icache_pkg::FILL) & biu_rsp_i.ack;
      if (cache_ack)
      begin
        lru_q[req_i.idx] <= ~hit_way;                     // Other way becomes victim
      end
      else if (fill_ok)
      begin
        lru_q[req_i.idx] <= ~lru_q[req_i.idx];            // Fresh line is MRU
      end
    end
  end

  // Fill result kept for the RECOVER parcel
  always_ff @(posedge clk_i)
  begin
    if ((state_q == icache_pkg::FILL) && biu_rsp_i.ack)
    begin
      fill_line_q <= biu_rsp_i.line;
      fill_err_q  <= biu_rsp_i.err;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Way write and bus command
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    wr_o.we    = fill_ok ? victim_oh : '0;               // Nothing written on error
    wr_o.idx   = req_i.idx;
    wr_o.tag   = req_i.tag;
    wr_o.line  = biu_rsp_i.line;
    wr_o.inval = (state_q == icache_pkg::FLUSH);
  end

  always_comb
  begin
    unique case (state_q)
      icache_pkg::FILL:         biu_cmd_o = icache_pkg::READ_LINE;
      icache_pkg::NONCACHEABLE: biu_cmd_o = icache_pkg::READ_WORD;
      default:                  biu_cmd_o = icache_pkg::NOP;
    endcase
  end

  assign biu_adr_o = req_i.adr;

  ////////////////////////////////////////////////////////////////////////////
  // Parcel to core
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    parcel_o       = hit_line[req_i.offs * icache_pkg::XLEN +: icache_pkg::XLEN];
    parcel_error_o = 1'b0;
    unique case (state_q)
      icache_pkg::ARMED:
      begin
        stall_o        = flush_req_i | (req_i.valid & ~(req_i.cacheable & any_hit));
        parcel_valid_o = cache_ack;
      end
      icache_pkg::NONCACHEABLE:
      begin
        stall_o        = ~biu_rsp_i.ack;                  // Word straight off the R beat
        parcel_valid_o = biu_rsp_i.ack;
        parcel_o       = biu_rsp_i.word;
        parcel_error_o = biu_rsp_i.ack & biu_rsp_i.err;
      end
      icache_pkg::RECOVER:
      begin
        stall_o        = ~pend_q;                         // Held after a flush
        parcel_valid_o = pend_q;
        parcel_o       = fill_line_q[req_i.offs * icache_pkg::XLEN +: icache_pkg::XLEN];
        parcel_error_o = pend_q & fill_err_q;
      end
      default:
      begin
        stall_o        = 1'b1;                            // FLUSH and FILL
        parcel_valid_o = 1'b0;
      end
    endcase
  end

  // Fetch proceeds anyway
  assign parcel_misaligned_o = |req_i.adr[icache_pkg::BYTE_BITS-1:0];

endmodule

//--- rtl/icache_biu.sv
module icache_biu (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  input  icache_pkg::biu_cmd_e cmd_i,      // Held until ack
  input  icache_pkg::addr_t    adr_i,
  output icache_pkg::biu_rsp_s rsp_o,

  // AXI4-Lite read channels
  output logic                 axi_arvalid_o,
  output icache_pkg::addr_t    axi_araddr_o,
  output logic [2:0]           axi_arprot_o,
  input  logic                 axi_arready_i,
  input  logic                 axi_rvalid_i,
  input  icache_pkg::word_t    axi_rdata_i,
  input  logic [1:0]           axi_rresp_i,
  output logic                 axi_rready_o
);

  typedef enum logic [1:0] {BIU_IDLE, BIU_ADDR, BIU_DATA} biu_state_e;

  biu_state_e          state_q;
  icache_pkg::offs_t   beat_q;       // Word within the line
  logic                err_q;        // Sticky over the beats
  logic                last_beat;
  logic                r_hs;         // R handshake
  icache_pkg::line_t   buf_q;

  assign last_beat = (cmd_i == icache_pkg::READ_WORD)
                   | (beat_q == icache_pkg::offs_t'(icache_pkg::LINE_WORDS - 1));
  assign r_hs      = (state_q == BIU_DATA) & axi_rvalid_i;

  // One read outstanding at a time
  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= BIU_IDLE;
      beat_q  <= '0;
      err_q   <= 1'b0;
    end
    else
    begin
      unique case (state_q)
        BIU_IDLE:
          if (cmd_i != icache_pkg::NOP)
          begin
            state_q <= BIU_ADDR;
            beat_q  <= '0;                            // Fills start at word 0
            err_q   <= 1'b0;
          end
        BIU_ADDR: if (axi_arready_i) state_q <= BIU_DATA;
        BIU_DATA:
          if (axi_rvalid_i)
          begin
            err_q <= err_q | (axi_rresp_i != icache_pkg::AXI_RESP_OKAY);
            if (last_beat)
            begin
              state_q <= BIU_IDLE;
            end
            else
            begin
              beat_q  <= beat_q + 1'b1;
              state_q <= BIU_ADDR;
            end
          end
        default: state_q <= BIU_IDLE;
      endcase
    end
  end

  // Line assembly
  always_ff @(posedge clk_i)
  begin
    if (r_hs)
    begin
      buf_q[beat_q * icache_pkg::XLEN +: icache_pkg::XLEN] <= axi_rdata_i;
    end
  end

  // Address is stable across the whole AR phase
  always_comb
  begin
    if (cmd_i == icache_pkg::READ_LINE)
      axi_araddr_o = {adr_i[icache_pkg::XLEN-1:icache_pkg::OFFS_BITS + icache_pkg::BYTE_BITS],
                      beat_q, {icache_pkg::BYTE_BITS{1'b0}}};
    else
      axi_araddr_o = {adr_i[icache_pkg::XLEN-1:icache_pkg::BYTE_BITS],
                      {icache_pkg::BYTE_BITS{1'b0}}};   // Word aligned
  end

  assign axi_arvalid_o = (state_q == BIU_ADDR);
  assign axi_rready_o  = (state_q == BIU_DATA);
  assign axi_arprot_o  = 3'b000;                       // Unprivileged, secure, data

  // Response, the last beat bypasses the buffer
  always_comb
  begin
    rsp_o.ack  = r_hs & last_beat;
    rsp_o.err  = err_q | (axi_rresp_i != icache_pkg::AXI_RESP_OKAY);
    rsp_o.word = axi_rdata_i;
    for (int w = 0; w < icache_pkg::LINE_WORDS; w++)
    begin
      rsp_o.line[w * icache_pkg::XLEN +: icache_pkg::XLEN] =
        (w == beat_q) ? axi_rdata_i : buf_q[w * icache_pkg::XLEN +: icache_pkg::XLEN];
    end
  end

endmodule

//--- rtl/icache_top.sv
module icache_top (
  input  logic              clk_i,
  input  logic              rst_ni,

  // Core side
  input  logic              req_i,
  input  icache_pkg::addr_t adr_i,
  output logic              stall_o,
  output icache_pkg::word_t parcel_o,
  output logic              parcel_valid_o,
  output logic              parcel_error_o,
  output logic              parcel_misaligned_o,
  input  logic              flush_req_i,          // Cache flush

  // AXI4-Lite read master
  output logic              axi_arvalid_o,
  output icache_pkg::addr_t axi_araddr_o,
  output logic [2:0]        axi_arprot_o,
  input  logic              axi_arready_i,
  input  logic              axi_rvalid_i,
  input  icache_pkg::word_t axi_rdata_i,
  input  logic [1:0]        axi_rresp_i,
  output logic              axi_rready_o
);

  icache_pkg::req_s     req;
  icache_pkg::way_rsp_s way_rsp [icache_pkg::WAYS];
  icache_pkg::way_wr_s  way_wr;
  icache_pkg::biu_cmd_e biu_cmd;
  icache_pkg::addr_t    biu_adr;
  icache_pkg::biu_rsp_s biu_rsp;

  ////////////////////////////////////////////////////////////////////////////
  // Setup stage and ways
  ////////////////////////////////////////////////////////////////////////////

  icache_setup u_setup (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req_i),
    .adr_i   (adr_i),
    .stall_i (stall_o),         // Hold while the hit stage is busy
    .req_o   (req)
  );

  for (genvar w = 0; w < icache_pkg::WAYS; w++)
  begin : g_way
    icache_way #(
      .WAY_ID (w)
    ) u_way (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .req_i  (req),
      .wr_i   (way_wr),
      .rsp_o  (way_rsp[w])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // Hit stage and bus unit
  ////////////////////////////////////////////////////////////////////////////

  icache_hit u_hit (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .req_i               (req),
    .way_rsp_i           (way_rsp),
    .flush_req_i         (flush_req_i),
    .wr_o                (way_wr),
    .biu_cmd_o           (biu_cmd),
    .biu_adr_o           (biu_adr),
    .biu_rsp_i           (biu_rsp),
    .stall_o             (stall_o),
    .parcel_o            (parcel_o),
    .parcel_valid_o      (parcel_valid_o),
    .parcel_error_o      (parcel_error_o),
    .parcel_misaligned_o (parcel_misaligned_o)
  );

  icache_biu u_biu (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmd_i         (biu_cmd),
    .adr_i         (biu_adr),
    .rsp_o         (biu_rsp),
    .axi_arvalid_o (axi_arvalid_o),
    .axi_araddr_o  (axi_araddr_o),
    .axi_arprot_o  (axi_arprot_o),
    .axi_arready_i (axi_arready_i),
    .axi_rvalid_i  (axi_rvalid_i),
    .axi_rdata_i   (axi_rdata_i),
    .axi_rresp_i   (axi_rresp_i),
    .axi_rready_o  (axi_rready_o)
  );

endmodule

//--- bench/icache_asserts.sv
module icache_asserts (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 axi_arvalid_i,
  input icache_pkg::addr_t    axi_araddr_i,
  input logic                 axi_arready_i,
  input logic                 axi_rready_i,
  input logic                 parcel_valid_i,
  input logic                 stall_i,
  input icache_pkg::way_rsp_s way_rsp_i [icache_pkg::WAYS]
);

  icache_pkg::way_oh_t hits;              // Hit flags of all ways
  int unsigned         fail_cnt = 0;      // Failed properties so far

  always_comb
  begin
    for (int w = 0; w < icache_pkg::WAYS; w++)
    begin
      hits[w] = way_rsp_i[w].hit;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // AXI and core side properties
  ////////////////////////////////////////////////////////////////////////////

  // Address held until the AR handshake
  ar_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_arvalid_i && !axi_arready_i |=> $stable(axi_araddr_i))
    else
    begin
      fail_cnt++;
      $error("ARADDR changed while ARVALID waited for ARREADY");
    end

  no_valid_in_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(parcel_valid_i && stall_i))
    else
    begin
      fail_cnt++;
      $error("parcel_valid_o and stall_o high together");
    end

  one_way_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(hits))
    else
    begin
      fail_cnt++;
      $error("More than one way hit");
    end

  // No bus traffic while in reset
  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> !axi_arvalid_i && !axi_rready_i)
    else
    begin
      fail_cnt++;
      $error("AXI outputs active during reset");
    end

endmodule

bind icache_top icache_asserts u_asserts (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .axi_arvalid_i  (axi_arvalid_o),
  .axi_araddr_i   (axi_araddr_o),
  .axi_arready_i  (axi_arready_i),
  .axi_rready_i   (axi_rready_o),
  .parcel_valid_i (parcel_valid_o),
  .stall_i        (stall_o),
  .way_rsp_i      (way_rsp)
);

//--- bench/icache_tb.sv
module icache_tb;

  logic              clk_i;
  logic              rst_ni;
  logic              req;
  icache_pkg::addr_t adr;
  logic              flush_req;
  logic              stall;
  icache_pkg::word_t parcel;
  logic              parcel_valid;
  logic              parcel_error;
  logic              parcel_misaligned;
  logic              arvalid;
  icache_pkg::addr_t araddr;
  logic [2:0]        arprot;
  logic              arready;
  logic              rvalid;
  icache_pkg::word_t rdata;
  logic [1:0]        rresp;
  logic              rready;

  logic              op_flush_q [$];        // One entry per stimulus line
  logic [31:0]       adr_q [$];
  logic [31:0]       word_q [$];
  int                reads_q [$];
  int                n_lines  = 0;
  bit                loaded   = 1'b0;       // Releases the watchdog
  int                errors   = 0;
  int                checks   = 0;
  int                ar_count = 0;          // AR handshakes seen by the memory
  int                ar_mark  = 0;
  logic [31:0]       rng      = 32'h4483_3e8d;

  icache_top UUT (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .req_i (req), .adr_i (adr), .stall_o (stall),
    .parcel_o (parcel), .parcel_valid_o (parcel_valid),
    .parcel_error_o (parcel_error), .parcel_misaligned_o (parcel_misaligned),
    .flush_req_i (flush_req),
    .axi_arvalid_o (arvalid), .axi_araddr_o (araddr), .axi_arprot_o (arprot),
    .axi_arready_i (arready), .axi_rvalid_i (rvalid), .axi_rdata_i (rdata),
    .axi_rresp_i (rresp), .axi_rready_o (rready)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;              // Period 8
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // Memory content, address inverted then rotated left by 7
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    logic [31:0] n;
    n = ~a;
    return {n[24:0], n[31:25]};
  endfunction

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // AXI4-Lite read slave
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin : axi_slave
    logic [31:0] a;
    forever
    begin
      @(negedge clk_i);                     // Sample DUT mid cycle
      if (arvalid)
      begin
        a   = araddr;
        compare_value("ARPROT", 32'(arprot), 32'h0);   // Always zero on AR
        rng = xorshift(rng);
        repeat (int'(rng[1:0])) @(posedge clk_i);
        @(posedge clk_i) arready <= 1'b1;
        @(posedge clk_i) arready <= 1'b0;   // Handshake on this edge
        ar_count++;
        rng = xorshift(rng);
        repeat (int'(rng[1:0])) @(posedge clk_i);
        @(posedge clk_i);
        rvalid <= 1'b1;
        rdata  <= mem_word(a);
        rresp  <= (a >= 32'h0000_F000 && a <= 32'h0000_F00F) ? 2'b10 : 2'b00;
        @(negedge clk_i);
        compare_value("RREADY during R beat", 32'(rready), 32'h1);
        @(posedge clk_i) rvalid <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Core side operations
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_fetch(input logic [31:0] a, input logic [31:0] exp_word,
                           input int exp_reads);
    logic err_exp;
    logic mis_exp;
    err_exp = (a >= 32'h0000_F000) && (a <= 32'h0000_F00F);
    mis_exp = |a[1:0];
    @(posedge clk_i);
    req <= 1'b1;
    adr <= a;
    @(posedge clk_i);
    req <= 1'b0;                            // Setup stage keeps the request
    do @(negedge clk_i); while (!(parcel_valid && !stall));
    compare_value($sformatf("parcel of %h", a), parcel, exp_word);
    compare_value("parcel_error_o", 32'(parcel_error), 32'(err_exp));
    compare_value("parcel_misaligned_o", 32'(parcel_misaligned), 32'(mis_exp));
    compare_value($sformatf("AR reads for %h", a), 32'(ar_count - ar_mark), 32'(exp_reads));
    ar_mark = ar_count;
  endtask

  task automatic run_flush(input int exp_reads);
    @(posedge clk_i) flush_req <= 1'b1;
    @(posedge clk_i) flush_req <= 1'b0;
    do @(negedge clk_i); while (stall);     // FLUSH then RECOVER
    compare_value("AR reads for flush", 32'(ar_count - ar_mark), 32'(exp_reads));
    ar_mark = ar_count;
  endtask

  initial
  begin : watchdog
    wait (loaded);
    repeat (n_lines * 200) @(posedge clk_i);
    $display("The run timed out before all stimulus lines were done");
    $display("Some tests failed");
    $finish;
  end

  initial
  begin : main
    int          fd;
    int          cnt;
    string       line;
    logic [63:0] op_txt;
    logic [31:0] a;
    logic [31:0] w;
    int          r;
    int          asrt_fails;
    rst_ni    <= 1'b0;
    req       <= 1'b0;
    adr       <= '0;
    flush_req <= 1'b0;
    arready   <= 1'b0;
    rvalid    <= 1'b0;
    rdata     <= '0;
    rresp     <= 2'b00;
    fd = $fopen("bench/icache_stimulus.txt", "r");
    if (fd == 0)
    begin
      $display("The stimulus file could not be opened");
      errors++;
    end
    else
    begin
      while ($fgets(line, fd) != 0)
      begin
        if (line.len() > 0 && line[0] != "#")
        begin
          cnt = $sscanf(line, "%s %h %h %d", op_txt, a, w, r);
          if (cnt == 4)
          begin
            op_flush_q.push_back(op_txt == 64'("flush"));
            adr_q.push_back(a);
            word_q.push_back(w);
            reads_q.push_back(r);
          end
        end
      end
      $fclose(fd);
    end
    n_lines = adr_q.size();
    loaded  = 1'b1;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int i = 0; i < n_lines; i++)
    begin
      if (op_flush_q[i])
        run_flush(reads_q[i]);
      else
        run_fetch(adr_q[i], word_q[i], reads_q[i]);
    end
    repeat (4) @(posedge clk_i);
    asrt_fails = UUT.u_asserts.fail_cnt;    // Bound checker's tally
    $display("Lines: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
             n_lines, checks, errors, asrt_fails);
    if (errors == 0 && asrt_fails == 0 && n_lines > 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

//--- icache_top.f
rtl/icache_pkg.sv
rtl/icache_setup.sv
rtl/icache_way.sv
rtl/icache_hit.sv
rtl/icache_biu.sv
rtl/icache_top.sv
bench/icache_asserts.sv
bench/icache_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the instruction cache testbench with Verilator, run it, then check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module icache_tb -f icache_top.f \
  -o icache_sim > build.log 2>&1 &&
  ./obj_dir/icache_sim > sim.log 2>&1 ||
  echo "Build or simulation did not complete, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q "^All tests passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- bench/icache_stimulus.txt
# op     address   expected word   AR reads since previous line
# word at an address is ~addr rotated left by 7, on the word aligned address
fetch 00000000 ffffffff 4
fetch 00000004 fffffdff 0
fetch 0000000c fffff9ff 0
fetch 00000008 fffffbff 0
fetch 80000010 fffff7bf 1
fetch 80000010 fffff7bf 1
fetch 80000100 ffff7fbf 1
fetch 00000040 ffffdfff 4
fetch 00000080 ffffbfff 4
fetch 00000044 ffffddff 0
fetch 00000000 ffffffff 4
fetch 00000048 ffffdbff 0
fetch 00000088 ffffbbff 4
fetch 00000004 fffffdff 4
fetch 00000084 ffffbdff 0
flush 00000000 00000000 0
fetch 00000084 ffffbdff 4
fetch 00000010 fffff7ff 4
fetch 00000014 fffff5ff 0
fetch 0000f000 ff87ffff 4
fetch 0000f004 ff87fdff 4
fetch 00000016 fffff5ff 0
fetch 00000032 ffffe7ff 4
fetch 0000003c ffffe1ff 0
fetch 80000002 ffffffbf 1
